// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // byte address and data word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 64;

    // line geometry
    localparam int LINE_WORDS = 8;
    localparam int LINE_W = LINE_WORDS * WORD_W;

    // address fields below the index
    localparam int OFFSET_W = 3;
    localparam int BYTE_W = 3;

    // controller states
    typedef enum logic [2:0] {
        // lookup, hit returns ok at once
        st_idle,
        // victim line or uncached store on the bus
        st_writeback,
        // line burst or uncached load
        st_refill,
        // pass-through result goes back to the cpu
        st_uncached_done,
        // walk every line and flush the dirty ones
        st_fence
    } ctrl_state_e;

endpackage

// ==== verilog/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array #(
    parameter int INDEX_W = 5,
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W - cache_pkg::BYTE_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index,
    input  logic [TAG_W-1:0]   tag,
    input  logic               touch,
    input  logic               fill,
    input  logic               clean,
    input  logic [INDEX_W:0]   clean_line,
    input  logic [INDEX_W:0]   sweep_line,
    input  logic               fill_way,
    input  logic               touch_write,
    output logic               hit,
    output logic               hit_way,
    output logic               victim_way,
    output logic               victim_dirty,
    output logic [TAG_W-1:0]   victim_tag,
    output logic               sweep_valid_dirty,
    output logic [TAG_W-1:0]   sweep_tag
);

    localparam int LINES = 2 ** (INDEX_W + 1);
    localparam int SETS = 2 ** INDEX_W;

    // line number is {index, way}
    logic [TAG_W-1:0] tag_mem [LINES];
    logic [LINES-1:0] valid_bits;
    logic [LINES-1:0] dirty_bits;
    // way used most recently, per set
    logic [SETS-1:0]  lru;

    logic [INDEX_W:0] line0;
    logic [INDEX_W:0] line1;
    logic             v0;
    logic             v1;
    logic             d0;
    logic             d1;
    logic             hit0;
    logic             hit1;

    assign line0 = {index, 1'b0};
    assign line1 = {index, 1'b1};
    assign v0 = valid_bits[line0];
    assign v1 = valid_bits[line1];
    assign d0 = dirty_bits[line0];
    assign d1 = dirty_bits[line1];

    assign hit0 = v0 && (tag_mem[line0] == tag);
    assign hit1 = v1 && (tag_mem[line1] == tag);
    assign hit = hit0 || hit1;
    assign hit_way = hit1;

    // invalid way first, then the clean one of a mixed pair, then not-recently-used
    always_comb begin
        if (!v0 || !v1) begin
            victim_way = v0;
        end else if (d0 != d1) begin
            victim_way = d0;
        end else begin
            victim_way = ~lru[index];
        end
    end

    assign victim_dirty = valid_bits[{index, victim_way}] && dirty_bits[{index, victim_way}];
    assign victim_tag = tag_mem[{index, victim_way}];

    assign sweep_valid_dirty = valid_bits[sweep_line] && dirty_bits[sweep_line];
    assign sweep_tag = tag_mem[sweep_line];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            lru <= '0;
        end else begin
            if (touch) begin
                lru[index] <= hit_way;
            end
            if (fill) begin
                valid_bits[{index, fill_way}] <= 1'b1;
            end
        end
    end

    // dirty set by a store hit, cleared by fill and write-back
    always_ff @(posedge clk) begin
        if (touch && touch_write) begin
            dirty_bits[{index, hit_way}] <= 1'b1;
        end
        if (fill) begin
            tag_mem[{index, fill_way}] <= tag;
            dirty_bits[{index, fill_way}] <= 1'b0;
        end
        if (clean) begin
            dirty_bits[clean_line] <= 1'b0;
        end
    end

    // a tag is only filled after a miss, so one set never holds it twice
    a_one_way_hits: assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1));

endmodule

// ==== verilog/cache_data_sram.sv ====
`timescale 1ns/1ps

module cache_data_sram #(
    parameter int INDEX_W = 5
) (
    input  logic                             clk,
    input  logic [INDEX_W:0]                 addr,
    input  logic [cache_pkg::LINE_WORDS-1:0] word_we,
    input  logic [cache_pkg::WORD_W/8-1:0]   strb,
    input  logic [cache_pkg::WORD_W-1:0]     wword,
    output logic [cache_pkg::LINE_W-1:0]     rline
);

    import cache_pkg::*;

    localparam int LINES = 2 ** (INDEX_W + 1);
    localparam int STRB_W = WORD_W / 8;

    // two ways per set, one full line per entry
    logic [LINE_W-1:0] mem [LINES];

    always_ff @(posedge clk) begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (word_we[w] && strb[b]) begin
                    mem[addr][w*WORD_W + b*8 +: 8] <= wword[b*8 +: 8];
                end
            end
        end
    end

    // read returns the old contents on a same-edge write
    always_ff @(posedge clk) begin
        rline <= mem[addr];
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int INDEX_W = 5,
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W - cache_pkg::BYTE_W
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             valid,
    input  logic                             op,
    input  logic [cache_pkg::ADDR_W-1:0]     addr,
    input  logic [cache_pkg::WORD_W/8-1:0]   wstrb,
    input  logic [cache_pkg::WORD_W-1:0]     wdata,
    input  logic                             fence,
    output logic                             ok,
    output logic                             ready,
    output logic [cache_pkg::WORD_W-1:0]     rdata,
    output logic                             err,
    output logic                             rd_req,
    output logic                             wr_req,
    output logic [cache_pkg::ADDR_W-1:0]     bus_addr,
    output logic [cache_pkg::LINE_W-1:0]     wr_data,
    output logic [cache_pkg::WORD_W/8-1:0]   wr_strb,
    input  logic                             rd_ready,
    input  logic                             rd_last,
    input  logic [cache_pkg::WORD_W-1:0]     rd_data,
    input  logic                             rd_error,
    input  logic                             wr_ready,
    input  logic                             wr_error,
    input  logic                             hit,
    input  logic                             hit_way,
    input  logic                             victim_way,
    input  logic                             victim_dirty,
    input  logic [TAG_W-1:0]                 victim_tag,
    input  logic                             sweep_valid_dirty,
    input  logic [TAG_W-1:0]                 sweep_tag,
    output logic                             touch,
    output logic                             fill,
    output logic                             clean,
    output logic [INDEX_W:0]                 clean_line,
    output logic [INDEX_W:0]                 sweep_line,
    output logic [INDEX_W:0]                 ram_addr,
    output logic [cache_pkg::LINE_WORDS-1:0] ram_word_we,
    output logic [cache_pkg::WORD_W/8-1:0]   ram_strb,
    output logic [cache_pkg::WORD_W-1:0]     ram_wword,
    input  logic [cache_pkg::LINE_W-1:0]     ram_line
);

    import cache_pkg::*;

    localparam int LINE_OFF_W = OFFSET_W + BYTE_W;

    ctrl_state_e           state;
    logic [OFFSET_W-1:0]   beat;
    logic [INDEX_W:0]      sweep;
    logic                  err_q;
    logic [OFFSET_W-1:0]   off_q;
    logic                  unc_q;
    logic [WORD_W-1:0]     unc_data;

    logic                  cached;
    logic [INDEX_W-1:0]    idx;
    logic [OFFSET_W-1:0]   offset;
    logic                  lookup;
    logic                  cached_hit;
    logic                  miss_wb;
    logic                  miss_rd;
    logic                  unc_wr;
    logic                  unc_rd;
    logic                  rd_beat;
    logic                  rd_done;
    logic                  wr_done;
    logic                  sweep_go;

    // bit 31 low means pass-through
    assign cached = addr[ADDR_W-1];
    assign idx = addr[LINE_OFF_W +: INDEX_W];
    assign offset = addr[BYTE_W +: OFFSET_W];

    assign lookup = (state == st_idle) && valid && !fence;
    assign cached_hit = lookup && cached && hit;
    assign miss_wb = lookup && cached && !hit && victim_dirty;
    assign miss_rd = lookup && cached && !hit && !victim_dirty;
    assign unc_wr = lookup && !cached && op;
    assign unc_rd = lookup && !cached && !op;
    assign rd_beat = rd_req && rd_ready;
    assign rd_done = rd_beat && rd_last;
    assign wr_done = wr_req && wr_ready;
    assign sweep_go = (state == st_fence) && !wr_req && sweep_valid_dirty;

    assign ok = cached_hit || (state == st_uncached_done);
    assign err = (state == st_uncached_done) && err_q;
    assign ready = (state != st_fence);

    assign touch = cached_hit;
    assign fill = (state == st_refill) && rd_done && cached;
    assign clean = wr_done && ((state == st_fence) || (state == st_writeback && cached));
    assign clean_line = (state == st_fence) ? sweep : {idx, victim_way};
    assign sweep_line = sweep;

    always_comb begin
        if (state == st_fence) begin
            ram_addr = sweep;
        end else if (state == st_idle && hit) begin
            ram_addr = {idx, hit_way};
        end else begin
            ram_addr = {idx, victim_way};
        end
    end

    always_comb begin
        ram_word_we = '0;
        if (cached_hit && op) begin
            ram_word_we[offset] = 1'b1;
        end else if (state == st_refill && rd_beat && cached) begin
            ram_word_we[beat] = 1'b1;
        end
    end

    assign ram_strb = (state == st_refill) ? '1 : wstrb;
    assign ram_wword = (state == st_refill) ? rd_data : wdata;

    // uncached store sends only the low word
    always_comb begin
        if (state == st_writeback && !cached) begin
            wr_data = {{(LINE_W-WORD_W){1'b0}}, wdata};
            wr_strb = wstrb;
        end else begin
            wr_data = ram_line;
            wr_strb = '1;
        end
    end

    always_comb begin
        if (unc_q) begin
            rdata = unc_data;
        end else begin
            rdata = ram_line[off_q*WORD_W +: WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            beat <= '0;
            sweep <= '0;
            err_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fence) begin
                        sweep <= '0;
                        state <= st_fence;
                    end else if (miss_wb || unc_wr) begin
                        wr_req <= 1'b1;
                        state <= st_writeback;
                    end else if (miss_rd || unc_rd) begin
                        rd_req <= 1'b1;
                        beat <= '0;
                        state <= st_refill;
                    end
                end
                st_writeback: begin
                    if (wr_done) begin
                        wr_req <= 1'b0;
                        if (!cached) begin
                            err_q <= wr_error;
                            state <= st_uncached_done;
                        end else begin
                            rd_req <= 1'b1;
                            beat <= '0;
                            state <= st_refill;
                        end
                    end
                end
                st_refill: begin
                    if (rd_beat) begin
                        beat <= beat + 1'b1;
                    end
                    if (rd_done) begin
                        rd_req <= 1'b0;
                        err_q <= rd_error;
                        state <= cached ? st_idle : st_uncached_done;
                    end
                end
                st_uncached_done: begin
                    state <= st_idle;
                end
                st_fence: begin
                    if (wr_req) begin
                        if (wr_ready) begin
                            wr_req <= 1'b0;
                            sweep <= sweep + 1'b1;
                            if (&sweep) state <= st_idle;
                        end
                    end else if (sweep_valid_dirty) begin
                        // line data shows up on ram_line next cycle
                        wr_req <= 1'b1;
                    end else begin
                        sweep <= sweep + 1'b1;
                        if (&sweep) state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_wb) begin
            bus_addr <= {victim_tag, idx, {LINE_OFF_W{1'b0}}};
        end else if (miss_rd || (state == st_writeback && wr_done && cached)) begin
            bus_addr <= {addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
        end else if (unc_wr || unc_rd) begin
            bus_addr <= {addr[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
        end else if (sweep_go) begin
            bus_addr <= {sweep_tag, sweep[INDEX_W:1], {LINE_OFF_W{1'b0}}};
        end
        if (rd_beat) begin
            unc_data <= rd_data;
        end
        off_q <= offset;
        unc_q <= !cached;
    end

    a_one_request: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req));

    // burst beats before the last one also keep the address
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        ((rd_req && !rd_done) || (wr_req && !wr_ready)) |=> $stable(bus_addr));

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid,
    input  logic                           op,
    input  logic [cache_pkg::ADDR_W-1:0]   addr,
    input  logic [cache_pkg::WORD_W/8-1:0] wstrb,
    input  logic [cache_pkg::WORD_W-1:0]   wdata,
    output logic                           ok,
    output logic                           ready,
    output logic [cache_pkg::WORD_W-1:0]   rdata,
    output logic                           err,
    input  logic                           fence,
    output logic                           rd_req,
    output logic                           wr_req,
    output logic [cache_pkg::ADDR_W-1:0]   bus_addr,
    output logic [cache_pkg::LINE_W-1:0]   wr_data,
    output logic [cache_pkg::WORD_W/8-1:0] wr_strb,
    input  logic                           rd_ready,
    input  logic                           rd_last,
    input  logic [cache_pkg::WORD_W-1:0]   rd_data,
    input  logic                           wr_ready,
    input  logic                           rd_error,
    input  logic                           wr_error
);

    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    logic                  sweep_valid_dirty;
    logic [TAG_W-1:0]      sweep_tag;
    logic                  touch;
    logic                  fill;
    logic                  clean;
    logic [INDEX_W:0]      clean_line;
    logic [INDEX_W:0]      sweep_line;
    logic [INDEX_W:0]      ram_addr;
    logic [LINE_WORDS-1:0] ram_word_we;
    logic [WORD_W/8-1:0]   ram_strb;
    logic [WORD_W-1:0]     ram_wword;
    logic [LINE_W-1:0]     ram_line;

    cache_ctrl #(.INDEX_W(INDEX_W)) ctrl_inst (.*);

    // victim choice holds steady for the whole miss, so it also picks the fill way
    cache_tag_array #(.INDEX_W(INDEX_W)) tag_inst (
        .clk, .rst,
        .index(addr[OFFSET_W+BYTE_W +: INDEX_W]),
        .tag(addr[ADDR_W-1 -: TAG_W]),
        .touch, .fill, .clean, .clean_line, .sweep_line,
        .fill_way(victim_way),
        .touch_write(op),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .sweep_valid_dirty, .sweep_tag
    );

    cache_data_sram #(.INDEX_W(INDEX_W)) sram_inst (
        .clk,
        .addr(ram_addr),
        .word_we(ram_word_we),
        .strb(ram_strb),
        .wword(ram_wword),
        .rline(ram_line)
    );

endmodule

// ==== bench/mem_bus_model.sv ====
`timescale 1ns/1ps

module mem_bus_model #(
    parameter logic [2:0] ERR_SEL = 3'b111
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           rd_req,
    input  logic                           wr_req,
    input  logic [cache_pkg::ADDR_W-1:0]   bus_addr,
    input  logic [cache_pkg::LINE_W-1:0]   wr_data,
    input  logic [cache_pkg::WORD_W/8-1:0] wr_strb,
    output logic                           rd_ready,
    output logic                           rd_last,
    output logic [cache_pkg::WORD_W-1:0]   rd_data,
    output logic                           rd_error,
    output logic                           wr_ready,
    output logic                           wr_error,
    output logic [31:0]                    beats,
    output logic [31:0]                    writes,
    output logic [31:0]                    hold_errors,
    output logic [cache_pkg::ADDR_W-1:0]   last_addr
);

    import cache_pkg::*;

    // word index is {addr[31], addr[12:3]}
    logic [WORD_W-1:0] mem [2048];
    logic [2:0]        beat;
    logic              uncached;
    logic              err_addr;
    logic [10:0]       word_sel;
    logic              rd_wait;
    logic              wr_wait;
    logic [ADDR_W-1:0] prev_addr;
    logic [LINE_W-1:0] prev_data;

    function automatic logic [63:0] fill_word(input logic [10:0] i);
        logic [31:0] byte_addr;
        byte_addr = {i[10], 18'd0, i[9:0], 3'd0};
        return {byte_addr * 32'h9e3779b9, byte_addr};
    endfunction

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] <= fill_word(11'(i));
        end
    end

    assign uncached = !bus_addr[31];
    assign err_addr = uncached && (bus_addr[12:10] == ERR_SEL);
    assign word_sel = {bus_addr[31], bus_addr[12:6], bus_addr[5:3] | beat};
    assign rd_ready = rd_req && !stall;
    assign rd_last = rd_ready && (uncached || (&beat));
    assign rd_data = mem[word_sel];
    assign rd_error = rd_last && err_addr;
    assign wr_ready = wr_req && !stall;
    assign wr_error = wr_ready && err_addr;

    always @(posedge clk) begin
        if (rst) begin
            beat <= '0;
            beats <= '0;
            writes <= '0;
            hold_errors <= '0;
            rd_wait <= 1'b0;
            wr_wait <= 1'b0;
            last_addr <= '0;
        end else begin
            if (rd_ready) begin
                beats <= beats + 32'd1;
                beat <= rd_last ? 3'd0 : beat + 3'd1;
                if (rd_last) begin
                    last_addr <= bus_addr;
                end
            end
            if (wr_ready) begin
                writes <= writes + 32'd1;
                last_addr <= bus_addr;
                if (!uncached) begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem[{1'b1, bus_addr[12:6], w[2:0]}] <= wr_data[w*WORD_W +: WORD_W];
                    end
                end else if (!err_addr) begin
                    // failed stores leave memory alone
                    for (int b = 0; b < WORD_W / 8; b++) begin
                        if (wr_strb[b]) begin
                            mem[word_sel][b*8 +: 8] <= wr_data[b*8 +: 8];
                        end
                    end
                end
            end
            if ((rd_wait && (!rd_req || bus_addr !== prev_addr)) ||
                (wr_wait && (!wr_req || bus_addr !== prev_addr || wr_data !== prev_data))) begin
                $display("MISMATCH at %0t: bus request changed while waiting, addr %h was %h",
                         $time, bus_addr, prev_addr);
                hold_errors <= hold_errors + 32'd1;
            end
            rd_wait <= rd_req && !rd_last;
            wr_wait <= wr_req && !wr_ready;
            prev_addr <= bus_addr;
            prev_data <= wr_data;
        end
    end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    import cache_pkg::*;

    localparam int INDEX_W = 5;
    localparam int NUM_OPS = 600;
    // a dirty miss with stalls stays well below this
    localparam int OP_CYCLES = 40;
    localparam int FENCE_CYCLES = 2 * (2 ** INDEX_W) * 8;
    localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES + 3 * FENCE_CYCLES + 100;
    localparam logic [2:0] ERR_SEL = 3'b111;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  valid;
    logic                  op;
    logic [ADDR_W-1:0]     addr;
    logic [WORD_W/8-1:0]   wstrb;
    logic [WORD_W-1:0]     wdata;
    logic                  fence;
    logic                  ok;
    logic                  ready;
    logic [WORD_W-1:0]     rdata;
    logic                  err;
    logic                  rd_req;
    logic                  wr_req;
    logic [ADDR_W-1:0]     bus_addr;
    logic [LINE_W-1:0]     wr_data;
    logic [WORD_W/8-1:0]   wr_strb;
    logic                  rd_ready;
    logic                  rd_last;
    logic [WORD_W-1:0]     rd_data;
    logic                  wr_ready;
    logic                  rd_error;
    logic                  wr_error;
    logic                  stall = 1'b0;
    logic [31:0]           beats;
    logic [31:0]           writes;
    logic [31:0]           hold_errors;
    logic [ADDR_W-1:0]     last_addr;

    logic [31:0]           rnd_state = 32'hb14c;
    logic [31:0]           stall_state = 32'hb14c;
    logic [WORD_W-1:0]     ref_mem [2048];
    int                    errors = 0;
    int                    cycles = 0;

    dcache_top #(.INDEX_W(INDEX_W)) dcache_top_inst (.*);

    mem_bus_model #(.ERR_SEL(ERR_SEL)) mem_bus_model_inst (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // roughly one stalled cycle in four
    always @(posedge clk) begin
        stall_state <= lcg_step(stall_state);
        stall <= (stall_state[30:29] == 2'b00);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                                 input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // 4 tags on 4 sets for cached, word addresses below bit 13 for uncached
    function automatic logic [31:0] make_addr(input logic [15:0] r);
        if (r[15:13] != 3'b000) begin
            return {1'b1, 18'd0, r[1:0], 3'd0, r[3:2], r[6:4], 3'd0};
        end else begin
            return {1'b0, 18'd0, r[11:2], 3'd0};
        end
    endfunction

    task automatic cpu_access(input logic [31:0] a, input logic is_write,
                              input logic [7:0] strb, input logic [63:0] data);
        logic [10:0] wi;
        logic        exp_err;
        logic [31:0] beats0;
        logic [31:0] writes0;
        logic [63:0] expected;
        wi = {a[31], a[12:3]};
        exp_err = !a[31] && (a[12:10] == ERR_SEL);
        beats0 = beats;
        writes0 = writes;
        expected = ref_mem[wi];
        @(posedge clk);
        valid <= 1'b1;
        op <= is_write;
        addr <= a;
        wstrb <= strb;
        wdata <= data;
        @(negedge clk);
        while (ok !== 1'b1) @(negedge clk);
        compare_value(64'(err), 64'(exp_err), "err with ok");
        if (is_write && !exp_err) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    ref_mem[wi][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        if (!is_write && !exp_err) begin
            compare_value(rdata, expected, "read data");
        end
        if (!a[31]) begin
            compare_value(64'(beats - beats0), is_write ? 64'd0 : 64'd1, "uncached read beats");
            compare_value(64'(writes - writes0), is_write ? 64'd1 : 64'd0, "uncached bus writes");
            compare_value(64'(last_addr), 64'(a), "uncached bus address");
        end
    endtask

    task automatic run_fence(input logic expect_quiet);
        logic [31:0] writes0;
        writes0 = writes;
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        compare_value(64'(ready), 64'd0, "ready while fence runs");
        while (ready !== 1'b1) @(negedge clk);
        if (expect_quiet) begin
            compare_value(64'(writes - writes0), 64'd0, "bus writes in repeated fence");
        end
    endtask

    initial begin
        logic [31:0] a;
        logic        is_write;
        logic [7:0]  strb;
        logic [63:0] data;
        rst <= 1'b1;
        valid <= 1'b0;
        op <= 1'b0;
        addr <= '0;
        wstrb <= '0;
        wdata <= '0;
        fence <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value(64'(ok), 64'd0, "ok after reset");
        compare_value(64'(rd_req), 64'd0, "rd_req after reset");
        compare_value(64'(wr_req), 64'd0, "wr_req after reset");
        compare_value(64'(ready), 64'd1, "ready after reset");

        // reference starts from the backing memory contents
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = mem_bus_model_inst.mem[i];
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            rnd_state = lcg_step(rnd_state);
            a = make_addr(rnd_state[31:16]);
            rnd_state = lcg_step(rnd_state);
            is_write = rnd_state[31];
            strb = rnd_state[30:23];
            rnd_state = lcg_step(rnd_state);
            data[63:32] = rnd_state;
            rnd_state = lcg_step(rnd_state);
            data[31:0] = rnd_state;
            cpu_access(a, is_write, strb, data);
            if (n == NUM_OPS / 2) begin
                run_fence(1'b0);
            end
        end

        run_fence(1'b0);
        for (int i = 0; i < 2048; i++) begin
            compare_value(mem_bus_model_inst.mem[i], ref_mem[i], "backing memory after fence");
        end
        run_fence(1'b1);

        $display("checks done: %0d mismatches, %0d bus hold errors", errors, hold_errors);
        if (errors == 0 && hold_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/cache_pkg.sv
verilog/cache_tag_array.sv
verilog/cache_data_sram.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
bench/mem_bus_model.sv
bench/dcache_tb.sv

// ==== Makefile ====
TOP := dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
